// ==== gpio_lite.f ====
rtl/gpio_pkg.sv
rtl/gpio_access_decode.sv
rtl/gpio_port_regs.sv
rtl/gpio_irq.sv
rtl/gpio_top.sv
testbench/gpio_asserts.sv
testbench/gpio_checker.sv
testbench/gpio_tb.sv

// ==== rtl/gpio_access_decode.sv ====
// Writes are single-cycle strobes; gready low only flags an error, writes are never stalled
`timescale 1ns/1ps

module gpio_access_decode import gpio_pkg::*;
(
  input  logic    HCLK,
  input  logic    HRESETn,
  input  io_req_t req,
  output wr_ctl_t wr,
  output logic    gready,
  output logic    gresp
);

  logic        write_trans;  // Qualified write cycle
  logic [1:0]  lane_en;
  logic        reserved;     // Write address with no writable register
  reg_sel_e    target;
  resp_state_e state_q;
  resp_state_e state_nxt;

  assign write_trans = req.sel & req.write & req.trans;

  // ========================================
  // Byte lanes
  // ========================================
  // Word, halfword at address bit 1 low, or byte at the matching offset
  assign lane_en[0] = req.size[1] | (~req.addr[1] & req.size[0]) | (req.addr[1:0] == 2'b00);
  assign lane_en[1] = req.size[1] | (~req.addr[1] & req.size[0]) | (req.addr[1:0] == 2'b01);

  // ========================================
  // Write target
  // ========================================
  always_comb
  begin
    target = NONE;
    if (write_trans && (req.addr[11:6] == 6'h00))  // Register window 0x000-0x03C
    begin
      case (req.addr[5:2])
        4'h0:    target = DATA;
        4'h1:    target = DATAOUT;
        4'h4:    target = OUTENSET;
        4'h5:    target = OUTENCLR;
        4'h6:    target = ALTFUNCSET;
        4'h7:    target = ALTFUNCCLR;
        4'h8:    target = INTENSET;
        4'h9:    target = INTENCLR;
        4'hA:    target = INTTYPESET;
        4'hB:    target = INTTYPECLR;
        4'hC:    target = INTPOLSET;
        4'hD:    target = INTPOLCLR;
        4'hE:    target = INTCLEAR;
        default: target = NONE;  // 0x2, 0x3 and 0xF hold nothing writable
      endcase
    end
  end

  assign wr.target    = target;
  assign wr.masked_lo = write_trans & (req.addr[11:10] == 2'b01) & lane_en[0];  // 0x400-0x7FC
  assign wr.masked_hi = write_trans & (req.addr[11:10] == 2'b10) & lane_en[1];  // 0x800-0xBFC
  assign wr.lane_en   = lane_en;
  assign wr.bit_mask  = req.addr[9:2];
  assign wr.wdata     = req.wdata[PORT_WIDTH-1:0];  // Little-endian, low half only

  // ========================================
  // Error response
  // ========================================
  // Offsets 0x8/0xC and the ID area at the top of the map
  assign reserved = (req.addr[11:2] == 10'h002) | (req.addr[11:2] == 10'h003) |
                    (req.addr >= 12'hFCF);

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_nxt;
    end
  end

  always_comb
  begin
    state_nxt = state_q;
    gready    = 1'b1;
    gresp     = 1'b0;
    case (state_q)
      IDLE:
      begin
        if (write_trans && reserved)
        begin
          state_nxt = NOT_READY;  // Only sampled here, later requests pass unchecked
        end
      end
      NOT_READY:
      begin
        gready    = 1'b0;
        gresp     = 1'b1;
        state_nxt = ERROR;
      end
      ERROR:
      begin
        gresp     = 1'b1;  // Second cycle of the two-cycle response
        state_nxt = IDLE;
      end
      default: state_nxt = IDLE;
    endcase
  end

endmodule

// ==== rtl/gpio_irq.sv ====
// port_in is seen two HCLK edges late, interrupt status one edge after that
`timescale 1ns/1ps

module gpio_irq import gpio_pkg::*;
(
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic [PORT_WIDTH-1:0] port_in,
  input  wr_ctl_t               wr,
  output irq_state_t            irq
);

  logic [PORT_WIDTH-1:0] sync1_q;
  logic [PORT_WIDTH-1:0] sync2_q;      // Synchronized input
  logic [PORT_WIDTH-1:0] last_q;       // Previous input, for edges
  logic [PORT_WIDTH-1:0] inten_q;
  logic [PORT_WIDTH-1:0] inttype_q;
  logic [PORT_WIDTH-1:0] intpol_q;
  logic [PORT_WIDTH-1:0] intstat_q;
  logic [PORT_WIDTH-1:0] level_int;
  logic [PORT_WIDTH-1:0] rise_int;
  logic [PORT_WIDTH-1:0] fall_int;
  logic [PORT_WIDTH-1:0] raw_int;
  logic [PORT_WIDTH-1:0] masked_int;
  logic [PORT_WIDTH-1:0] clr_bits;     // Write-one-to-clear bits

  // ========================================
  // Input synchronizer
  // ========================================
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      sync1_q <= '0;
      sync2_q <= '0;
    end
    else
    begin
      sync1_q <= port_in;
      sync2_q <= sync1_q;
    end
  end

  // Edge history only moves while some pin is edge type
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      last_q <= '0;
    end
    else if (|inttype_q)
    begin
      last_q <= sync2_q;
    end
  end

  // ========================================
  // Configuration
  // ========================================
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      inten_q   <= '0;
      inttype_q <= '0;
      intpol_q  <= '0;
    end
    else
    begin
      inten_q   <= set_clr(inten_q, wr, INTENSET, INTENCLR);
      inttype_q <= set_clr(inttype_q, wr, INTTYPESET, INTTYPECLR);
      intpol_q  <= set_clr(intpol_q, wr, INTPOLSET, INTPOLCLR);
    end
  end

  // ========================================
  // Detection and status
  // ========================================
  assign level_int  = ~inttype_q & ~(sync2_q ^ intpol_q);              // Input equals polarity
  assign rise_int   = inttype_q & intpol_q & sync2_q & ~last_q;
  assign fall_int   = inttype_q & ~intpol_q & ~sync2_q & last_q;
  assign raw_int    = level_int | rise_int | fall_int;
  assign masked_int = raw_int & inten_q;

  assign clr_bits = (wr.target == INTCLEAR) ? (wr.wdata & lane_mask(wr.lane_en)) : '0;

  // A new interrupt wins over a clear on the same pin
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      intstat_q <= '0;
    end
    else
    begin
      intstat_q <= (intstat_q & ~clr_bits) | masked_int;
    end
  end

  assign irq.datain  = sync2_q;
  assign irq.inten   = inten_q;
  assign irq.inttype = inttype_q;
  assign irq.intpol  = intpol_q;
  assign irq.intstat = intstat_q;

endmodule

// ==== rtl/gpio_pkg.sv ====
// 16 pins on two 8-bit lanes, little-endian data lanes only, single HCLK domain
package gpio_pkg;

  // ========================================
  // Sizes
  // ========================================
  localparam int PORT_WIDTH = 16;  // Fixed, logic is built on two byte lanes
  localparam int HALF_WIDTH = 8;   // One byte lane of pins

  // Write target, word offset in the low 4 bits, NONE outside the 4-bit range
  typedef enum logic [4:0] {
    DATA       = 5'h00,
    DATAOUT    = 5'h01,
    OUTENSET   = 5'h04,
    OUTENCLR   = 5'h05,
    ALTFUNCSET = 5'h06,
    ALTFUNCCLR = 5'h07,
    INTENSET   = 5'h08,
    INTENCLR   = 5'h09,
    INTTYPESET = 5'h0A,
    INTTYPECLR = 5'h0B,
    INTPOLSET  = 5'h0C,
    INTPOLCLR  = 5'h0D,
    INTCLEAR   = 5'h0E,
    NONE       = 5'h10
  } reg_sel_e;

  // Error response sequence
  typedef enum logic [1:0] {
    IDLE      = 2'b00,
    NOT_READY = 2'b01,  // gready low, gresp high
    ERROR     = 2'b10   // Both high
  } resp_state_e;

  // ========================================
  // Bundles
  // ========================================
  typedef struct packed {
    logic        sel;
    logic [11:0] addr;
    logic        write;
    logic [1:0]  size;   // 0 byte, 1 halfword, 2 word
    logic        trans;
    logic [31:0] wdata;
  } io_req_t;

  typedef struct packed {
    reg_sel_e              target;
    logic                  masked_lo;  // Write into low byte mask region
    logic                  masked_hi;  // Write into high byte mask region
    logic [1:0]            lane_en;
    logic [HALF_WIDTH-1:0] bit_mask;   // Address bits 9:2
    logic [PORT_WIDTH-1:0] wdata;
  } wr_ctl_t;

  typedef struct packed {
    logic [PORT_WIDTH-1:0] dout;
    logic [PORT_WIDTH-1:0] douten;
    logic [PORT_WIDTH-1:0] altfunc;  // Already gated by the function mask
  } port_state_t;

  typedef struct packed {
    logic [PORT_WIDTH-1:0] datain;   // After the two-flop synchronizer
    logic [PORT_WIDTH-1:0] inten;
    logic [PORT_WIDTH-1:0] inttype;  // 1 edge, 0 level
    logic [PORT_WIDTH-1:0] intpol;   // 1 high/rising, 0 low/falling
    logic [PORT_WIDTH-1:0] intstat;
  } irq_state_t;

  // Expand the two lane enables to one bit per pin
  function automatic logic [PORT_WIDTH-1:0] lane_mask(input logic [1:0] lane_en);
    lane_mask = {{HALF_WIDTH{lane_en[1]}}, {HALF_WIDTH{lane_en[0]}}};
  endfunction

  // Next value of a set/clear register pair
  function automatic logic [PORT_WIDTH-1:0] set_clr(input logic [PORT_WIDTH-1:0] cur,
                                                    input wr_ctl_t               wr,
                                                    input reg_sel_e              set_sel,
                                                    input reg_sel_e              clr_sel);
    logic [PORT_WIDTH-1:0] bits;
    bits    = wr.wdata & lane_mask(wr.lane_en);  // Only bytes that were written
    set_clr = cur;
    if (wr.target == set_sel)
    begin
      set_clr = cur | bits;
    end
    else if (wr.target == clr_sel)
    begin
      set_clr = cur & ~bits;
    end
  endfunction

endpackage

// ==== rtl/gpio_port_regs.sv ====
// Acts only on decoded write controls; altfunc reset value is gated by the function mask
`timescale 1ns/1ps

module gpio_port_regs import gpio_pkg::*;
#(
  parameter logic [PORT_WIDTH-1:0] ALT_FUNC_MASK    = 16'hFFFF,  // Pins that have a function
  parameter logic [PORT_WIDTH-1:0] ALT_FUNC_DEFAULT = 16'h0000   // Function select at reset
)
(
  input  logic        HCLK,
  input  logic        HRESETn,
  input  wr_ctl_t     wr,
  output port_state_t ports
);

  logic [PORT_WIDTH-1:0] dout_q;
  logic [PORT_WIDTH-1:0] dout_nxt;
  logic [PORT_WIDTH-1:0] douten_q;
  logic [PORT_WIDTH-1:0] altfunc_q;
  logic                  plain_write;  // DATA or DATAOUT

  assign plain_write = (wr.target == DATA) || (wr.target == DATAOUT);

  // ========================================
  // Output data
  // ========================================
  always_comb
  begin
    dout_nxt = dout_q;

    // Low byte, plain write wins over the mask region
    if (plain_write && wr.lane_en[0])
    begin
      dout_nxt[HALF_WIDTH-1:0] = wr.wdata[HALF_WIDTH-1:0];
    end
    else if (wr.masked_lo)
    begin
      dout_nxt[HALF_WIDTH-1:0] = (wr.wdata[HALF_WIDTH-1:0] & wr.bit_mask) |
                                 (dout_q[HALF_WIDTH-1:0] & ~wr.bit_mask);
    end

    // High byte, same rules with lane 1
    if (plain_write && wr.lane_en[1])
    begin
      dout_nxt[PORT_WIDTH-1:HALF_WIDTH] = wr.wdata[PORT_WIDTH-1:HALF_WIDTH];
    end
    else if (wr.masked_hi)
    begin
      dout_nxt[PORT_WIDTH-1:HALF_WIDTH] = (wr.wdata[PORT_WIDTH-1:HALF_WIDTH] & wr.bit_mask) |
                                          (dout_q[PORT_WIDTH-1:HALF_WIDTH] & ~wr.bit_mask);
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      dout_q <= '0;
    end
    else
    begin
      dout_q <= dout_nxt;  // Holds when nothing addressed it
    end
  end

  // ========================================
  // Output enable and alternate function
  // ========================================
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      douten_q <= '0;
    end
    else
    begin
      douten_q <= set_clr(douten_q, wr, OUTENSET, OUTENCLR);
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      altfunc_q <= ALT_FUNC_DEFAULT;
    end
    else
    begin
      altfunc_q <= set_clr(altfunc_q, wr, ALTFUNCSET, ALTFUNCCLR);
    end
  end

  assign ports.dout    = dout_q;
  assign ports.douten  = douten_q;
  assign ports.altfunc = altfunc_q & ALT_FUNC_MASK;  // Pins without a function read zero

endmodule

// ==== rtl/gpio_top.sv ====
// ID register area reads zero; io_rdata is combinational from io_addr
`timescale 1ns/1ps

module gpio_top import gpio_pkg::*;
#(
  parameter logic [PORT_WIDTH-1:0] ALT_FUNC_MASK    = 16'hFFFF,
  parameter logic [PORT_WIDTH-1:0] ALT_FUNC_DEFAULT = 16'h0000
)
(
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  io_sel,     // Peripheral select
  input  logic [11:0]           io_addr,
  input  logic                  io_write,
  input  logic [1:0]            io_size,
  input  logic                  io_trans,
  input  logic [31:0]           io_wdata,
  input  logic [PORT_WIDTH-1:0] port_in,
  output logic [31:0]           io_rdata,
  output logic                  gready,
  output logic                  gresp,
  output logic [PORT_WIDTH-1:0] port_out,
  output logic [PORT_WIDTH-1:0] port_en,
  output logic [PORT_WIDTH-1:0] port_func,
  output logic [PORT_WIDTH-1:0] gpio_int,   // Per-pin interrupt
  output logic                  comb_int    // Any pin
);

  io_req_t               req;
  wr_ctl_t               wr;
  port_state_t           ports;
  irq_state_t            irq;
  logic [PORT_WIDTH-1:0] rd_word;

  assign req = '{sel:   io_sel,
                 addr:  io_addr,
                 write: io_write,
                 size:  io_size,
                 trans: io_trans,
                 wdata: io_wdata};

  // ========================================
  // Blocks
  // ========================================
  gpio_access_decode u_decode (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .req     (req),
    .wr      (wr),
    .gready  (gready),
    .gresp   (gresp)
  );

  gpio_port_regs #(
    .ALT_FUNC_MASK    (ALT_FUNC_MASK),
    .ALT_FUNC_DEFAULT (ALT_FUNC_DEFAULT)
  ) u_port_regs (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .wr      (wr),
    .ports   (ports)
  );

  gpio_irq u_irq (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .port_in (port_in),
    .wr      (wr),
    .irq     (irq)
  );

  // ========================================
  // Read-back
  // ========================================
  always_comb
  begin
    rd_word = '0;
    case (io_addr[11:10])
      2'b00:
      begin
        if (io_addr[9:6] == 4'h0)
        begin
          case (io_addr[5:2])
            4'h0:       rd_word = irq.datain;
            4'h1:       rd_word = ports.dout;
            4'h4, 4'h5: rd_word = ports.douten;   // Set and clear read the same
            4'h6, 4'h7: rd_word = ports.altfunc;
            4'h8, 4'h9: rd_word = irq.inten;
            4'hA, 4'hB: rd_word = irq.inttype;
            4'hC, 4'hD: rd_word = irq.intpol;
            4'hE:       rd_word = irq.intstat;
            default:    rd_word = '0;
          endcase
        end
      end
      // Masked input reads, mask from address bits 9:2
      2'b01: rd_word[HALF_WIDTH-1:0] = irq.datain[HALF_WIDTH-1:0] & io_addr[9:2];
      2'b10: rd_word[PORT_WIDTH-1:HALF_WIDTH] = irq.datain[PORT_WIDTH-1:HALF_WIDTH] & io_addr[9:2];
      default: rd_word = '0;
    endcase
  end

  assign io_rdata = {{(32-PORT_WIDTH){1'b0}}, rd_word};

  assign port_out  = ports.dout;
  assign port_en   = ports.douten;
  assign port_func = ports.altfunc;
  assign gpio_int  = irq.intstat;
  assign comb_int  = |irq.intstat;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the GPIO testbench with Verilator, verdict taken from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module gpio_tb -f gpio_lite.f -o gpio_sim

# A stopped run must still leave its log for the search below
./obj_dir/gpio_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF 'All tests passed!' sim.log
then
  echo "Simulation OK"
else
  echo "Simulation FAILED, see sim.log"
  exit 1
fi

// ==== testbench/gpio_asserts.sv ====
// Bound into the access decoder; sampled on HCLK, response checks are off during reset
`timescale 1ns/1ps

module gpio_asserts import gpio_pkg::*;
(
  input logic    HCLK,
  input logic    HRESETn,
  input io_req_t req,
  input wr_ctl_t wr,
  input logic    gready,
  input logic    gresp
);

  // ========================================
  // Error response shape
  // ========================================
  a_low_ready_resp: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !gready |-> gresp)
    else $error("gready low while gresp low");

  // NOT_READY lasts one cycle, ERROR follows
  a_second_cycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !gready |=> (gready && gresp))
    else $error("gready low not followed by the ERROR cycle");

  // ========================================
  // Write decode
  // ========================================
  a_no_idle_write: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !req.trans |-> ((wr.target == NONE) && !wr.masked_lo && !wr.masked_hi))
    else $error("write decoded without a transfer");

  a_reset_idle: assert property (@(posedge HCLK)
    !HRESETn |-> (gready && !gresp))
    else $error("response outputs not idle in reset");

endmodule

// ==== testbench/gpio_checker.sv ====
// Cycle model built from the bus rules; sizes above word (3) are not modeled
`timescale 1ns/1ps

module gpio_checker import gpio_pkg::*;
#(
  parameter logic [PORT_WIDTH-1:0] ALT_FUNC_MASK    = 16'hFFFF,
  parameter logic [PORT_WIDTH-1:0] ALT_FUNC_DEFAULT = 16'h0000
)
(
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  io_sel, io_write, io_trans,
  input  logic [11:0]           io_addr,
  input  logic [1:0]            io_size,
  input  logic [31:0]           io_wdata,
  input  logic [31:0]           io_rdata,
  input  logic [PORT_WIDTH-1:0] port_in, port_out, port_en, port_func, gpio_int,
  input  logic                  gready, gresp, comb_int,
  input  logic                  test_end,     // Close the running test here
  input  logic [2:0]            test_id,
  input  logic                  timeout_hit,  // One error for the running test
  output int                    n_pass,
  output int                    n_fail,
  output int                    n_err
);

  logic [PORT_WIDTH-1:0] m_dout, m_en, m_alt, m_inten, m_type, m_pol, m_stat;
  logic [PORT_WIDTH-1:0] m_s1, m_s2, m_last;  // Input pipeline and edge history
  int                    m_phase;             // 0 idle, 1 not ready, 2 error
  int                    test_errs;

  // ========================================
  // Reference model, one step per edge
  // ========================================
  always @(posedge HCLK or negedge HRESETn)
  begin : model_step
    logic                  wr_on;
    logic                  ln0;
    logic                  ln1;
    logic                  reserved;
    logic [PORT_WIDTH-1:0] lm;
    logic [PORT_WIDTH-1:0] bits;
    logic [PORT_WIDTH-1:0] clr;
    logic [PORT_WIDTH-1:0] hit;
    logic [7:0]            mask;
    if (!HRESETn)
    begin
      m_dout  = '0;
      m_en    = '0;
      m_alt   = ALT_FUNC_DEFAULT;
      m_inten = '0;
      m_type  = '0;
      m_pol   = '0;
      m_stat  = '0;
      m_s1    = '0;
      m_s2    = '0;
      m_last  = '0;
      m_phase = 0;
    end
    else
    begin
      wr_on = io_sel && io_write && io_trans;
      ln0   = (io_size == 2'd2) || ((io_size == 2'd1) && !io_addr[1]) ||
              ((io_size == 2'd0) && (io_addr[1:0] == 2'd0));
      ln1   = (io_size == 2'd2) || ((io_size == 2'd1) && !io_addr[1]) ||
              ((io_size == 2'd0) && (io_addr[1:0] == 2'd1));
      lm    = {{8{ln1}}, {8{ln0}}};
      bits  = io_wdata[15:0] & lm;  // Written bits of enabled lanes
      mask  = io_addr[9:2];
      reserved = (io_addr[11:2] == 10'h002) || (io_addr[11:2] == 10'h003) ||
                 (io_addr >= 12'hFCF);
      // Interrupts from state before this edge
      hit = m_inten & ((~m_type & ~(m_s2 ^ m_pol)) |      // Level equals polarity
                       (m_type & m_pol & m_s2 & ~m_last) |  // Rising
                       (m_type & ~m_pol & ~m_s2 & m_last)); // Falling
      clr = (wr_on && (io_addr[11:2] == 10'h00E)) ? bits : '0;
      m_stat = (m_stat & ~(hit | clr)) | hit;  // Loads raw value on hit or clear
      if (|m_type)
      begin
        m_last = m_s2;
      end
      m_s2 = m_s1;
      m_s1 = port_in;
      if (wr_on && (io_addr[11:6] == 6'h00))
      begin
        case (io_addr[5:2])
          4'h0, 4'h1: m_dout = (m_dout & ~lm) | bits;
          4'h4: m_en    = m_en | bits;
          4'h5: m_en    = m_en & ~bits;
          4'h6: m_alt   = m_alt | bits;
          4'h7: m_alt   = m_alt & ~bits;
          4'h8: m_inten = m_inten | bits;
          4'h9: m_inten = m_inten & ~bits;
          4'hA: m_type  = m_type | bits;
          4'hB: m_type  = m_type & ~bits;
          4'hC: m_pol   = m_pol | bits;
          4'hD: m_pol   = m_pol & ~bits;
          default: ;  // INTCLEAR handled above, others hold nothing
        endcase
      end
      if (wr_on && (io_addr[11:10] == 2'b01) && ln0)
      begin
        m_dout[7:0] = (m_dout[7:0] & ~mask) | (io_wdata[7:0] & mask);
      end
      if (wr_on && (io_addr[11:10] == 2'b10) && ln1)
      begin
        m_dout[15:8] = (m_dout[15:8] & ~mask) | (io_wdata[15:8] & mask);
      end
      case (m_phase)
        0: m_phase = (wr_on && reserved) ? 1 : 0;  // Checked only when idle
        1: m_phase = 2;
        default: m_phase = 0;
      endcase
    end
  end

  // Read data for the address on the bus
  function automatic logic [31:0] expected_rdata(input logic [11:0] a);
    logic [31:0] v;
    v = '0;
    if (a[11:6] == 6'h00)
    begin
      case (a[5:2])
        4'h0: v[15:0] = m_s2;
        4'h1: v[15:0] = m_dout;
        4'h4, 4'h5: v[15:0] = m_en;
        4'h6, 4'h7: v[15:0] = m_alt & ALT_FUNC_MASK;
        4'h8, 4'h9: v[15:0] = m_inten;
        4'hA, 4'hB: v[15:0] = m_type;
        4'hC, 4'hD: v[15:0] = m_pol;
        4'hE: v[15:0] = m_stat;
        default: v = '0;
      endcase
    end
    else if (a[11:10] == 2'b01)
    begin
      v[7:0] = m_s2[7:0] & a[9:2];
    end
    else if (a[11:10] == 2'b10)
    begin
      v[15:8] = m_s2[15:8] & a[9:2];
    end
    return v;
  endfunction

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1: return "reset values";
      3'd2: return "register writes and read-back";
      3'd3: return "masked output writes";
      3'd4: return "input reads";
      3'd5: return "interrupts";
      3'd6: return "reserved write response";
      default: return "unnamed";
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    if (got !== want)
    begin
      $display("FAIL %s: expected %h, got %h", name, want, got);
      test_errs = test_errs + 1;
      n_err     = n_err + 1;
    end
  endtask

  // ========================================
  // Compare at the falling edge when outputs have settled
  // ========================================
  always @(negedge HCLK)
  begin
    if (!HRESETn)
    begin
      n_pass    = 0;
      n_fail    = 0;
      n_err     = 0;
      test_errs = 0;
    end
    else
    begin
      compare_value("port_out", 32'(port_out), 32'(m_dout));
      compare_value("port_en", 32'(port_en), 32'(m_en));
      compare_value("port_func", 32'(port_func), 32'(m_alt & ALT_FUNC_MASK));
      compare_value("gpio_int", 32'(gpio_int), 32'(m_stat));
      compare_value("comb_int", 32'(comb_int), 32'(|m_stat));
      compare_value("gready", 32'(gready), (m_phase == 1) ? 32'd0 : 32'd1);
      compare_value("gresp", 32'(gresp), (m_phase == 0) ? 32'd0 : 32'd1);
      compare_value("io_rdata", io_rdata, expected_rdata(io_addr));
      if (timeout_hit)
      begin
        test_errs = test_errs + 1;
        n_err     = n_err + 1;
      end
      if (test_end)
      begin
        if (test_errs == 0)
        begin
          n_pass = n_pass + 1;
          $display("Test %0d (%s): ok", test_id, test_name(test_id));
        end
        else
        begin
          n_fail = n_fail + 1;
          $display("Test %0d (%s): %0d errors", test_id, test_name(test_id), test_errs);
        end
        test_errs = 0;
      end
    end
  end

endmodule

// ==== testbench/gpio_tb.sv ====
// Random bus and pin stimulus from a fixed xorshift seed, transfer sizes 0 to 2 only
`timescale 1ns/1ps

module gpio_tb;

  localparam logic [15:0] FUNC_MASK    = 16'h0FFF;
  localparam logic [15:0] FUNC_DEFAULT = 16'h00F0;
  localparam int          WAIT_LIMIT   = 16;  // Cycles allowed for any response

  logic        HCLK, HRESETn;
  logic        io_sel, io_write, io_trans;
  logic [11:0] io_addr;
  logic [1:0]  io_size;
  logic [31:0] io_wdata, io_rdata;
  logic [15:0] port_in, port_out, port_en, port_func, gpio_int;
  logic        gready, gresp, comb_int;
  logic        test_end, timeout_hit;
  logic [2:0]  test_id;
  int          n_pass, n_fail, n_err;
  logic [31:0] rng;  // Random state

  always #2 HCLK = ~HCLK;  // 4 ns period

  gpio_top #(
    .ALT_FUNC_MASK    (FUNC_MASK),
    .ALT_FUNC_DEFAULT (FUNC_DEFAULT)
  ) dut_i (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .io_sel   (io_sel),
    .io_addr  (io_addr),
    .io_write (io_write),
    .io_size  (io_size),
    .io_trans (io_trans),
    .io_wdata (io_wdata),
    .port_in  (port_in),
    .io_rdata (io_rdata),
    .gready   (gready),
    .gresp    (gresp),
    .port_out (port_out),
    .port_en  (port_en),
    .port_func(port_func),
    .gpio_int (gpio_int),
    .comb_int (comb_int)
  );

  gpio_checker #(
    .ALT_FUNC_MASK    (FUNC_MASK),
    .ALT_FUNC_DEFAULT (FUNC_DEFAULT)
  ) checker_i (.*);

  bind gpio_access_decode gpio_asserts asserts_i (
    .HCLK(HCLK), .HRESETn(HRESETn), .req(req), .wr(wr), .gready(gready), .gresp(gresp)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Register window address, word offsets 0x2 and 0x3 skipped
  function automatic logic [11:0] reg_addr(input logic [31:0] r);
    logic [3:0] off;
    off = 4'(r[7:0] % 8'd13);
    if (off >= 4'd2)
    begin
      off = off + 4'd2;
    end
    return {6'h00, off, r[9:8]};
  endfunction

  // ========================================
  // Bus cycles, one per rising edge
  // ========================================
  task automatic write_reg(input logic [11:0] addr, input logic [1:0] size,
                           input logic [31:0] data);
    @(posedge HCLK);
    io_sel   <= 1'b1;
    io_addr  <= addr;
    io_write <= 1'b1;
    io_size  <= size;
    io_trans <= 1'b1;
    io_wdata <= data;
  endtask

  task automatic read_reg(input logic [11:0] addr);
    @(posedge HCLK);
    io_sel   <= 1'b1;
    io_addr  <= addr;
    io_write <= 1'b0;
    io_size  <= 2'd2;
    io_trans <= 1'b1;
  endtask

  task automatic idle_cycle();
    @(posedge HCLK);
    io_sel   <= 1'b0;
    io_write <= 1'b0;
    io_trans <= 1'b0;
  endtask

  // Set the given bits, clear all others
  task automatic config_pair(input logic [11:0] set_addr, input logic [31:0] bits);
    write_reg(set_addr, 2'd2, bits);
    write_reg(set_addr + 12'h004, 2'd2, ~bits);
  endtask

  task automatic close_test(input logic [2:0] id);
    idle_cycle();
    test_id  <= id;
    test_end <= 1'b1;
    @(posedge HCLK);
    test_end <= 1'b0;
  endtask

  task automatic wait_for_gready(input logic level, input string what);
    int n;
    n = 0;
    @(negedge HCLK);
    while ((gready !== level) && (n < WAIT_LIMIT))
    begin
      @(negedge HCLK);
      n = n + 1;
    end
    if (gready !== level)
    begin
      $display("Timeout: gready never went to %0d during %s", level, what);
      @(posedge HCLK);
      timeout_hit <= 1'b1;
      @(posedge HCLK);
      timeout_hit <= 1'b0;
    end
  endtask

  // ========================================
  // Test sequence
  // ========================================
  initial
  begin : stimulus
    int          i;
    int          k;
    logic [11:0] a;
    HCLK        = 1'b0;
    HRESETn     = 1'b0;
    io_sel      = 1'b0;
    io_addr     = '0;
    io_write    = 1'b0;
    io_size     = 2'd0;
    io_trans    = 1'b0;
    io_wdata    = '0;
    port_in     = '0;
    test_end    = 1'b0;
    test_id     = 3'd0;
    timeout_hit = 1'b0;
    rng         = 32'hd67e7907;
    repeat (10) @(posedge HCLK);
    HRESETn <= 1'b1;

    repeat (3) idle_cycle();  // Reset values checked every cycle
    close_test(3'd1);

    for (i = 0; i < 60; i++)
    begin
      rng = xorshift32(rng);
      a   = reg_addr(rng);
      write_reg(a, 2'(rng[31:16] % 16'd3), xorshift32(rng));
      read_reg({a[11:2], 2'b00});
    end
    close_test(3'd2);

    for (i = 0; i < 40; i++)
    begin
      rng = xorshift32(rng);
      a   = {(rng[0] ? 2'b10 : 2'b01), rng[15:8], rng[17:16]};
      write_reg(a, 2'(rng[31:20] % 12'd3), xorshift32(rng));
    end
    close_test(3'd3);

    for (i = 0; i < 8; i++)
    begin
      rng = xorshift32(rng);
      idle_cycle();
      port_in <= rng[15:0];
      repeat (3) idle_cycle();  // Through the synchronizer
      read_reg(12'h000);
      read_reg({2'b01, rng[23:16], 2'b00});
      read_reg({2'b10, rng[31:24], 2'b00});
    end
    close_test(3'd4);

    for (i = 0; i < 12; i++)
    begin
      rng = xorshift32(rng);
      config_pair(12'h020, rng);  // Enable
      rng = xorshift32(rng);
      config_pair(12'h028, rng);  // Type
      rng = xorshift32(rng);
      config_pair(12'h030, rng);  // Polarity
      write_reg(12'h038, 2'd2, 32'h0000FFFF);
      for (k = 0; k < 12; k++)
      begin
        rng = xorshift32(rng);
        if ((k % 3) == 2)
        begin
          write_reg(12'h038, 2'd2, xorshift32(rng));
        end
        else
        begin
          idle_cycle();
        end
        port_in <= rng[15:0];
      end
      repeat (3) idle_cycle();
      write_reg(12'h038, 2'd2, 32'h0000FFFF);  // Level bits stay, edge bits go
      repeat (3) idle_cycle();
    end
    close_test(3'd5);

    for (i = 0; i < 6; i++)
    begin
      rng = xorshift32(rng);
      case (rng[1:0])
        2'd0: a = {10'h002, rng[9:8]};
        2'd1: a = {10'h003, rng[9:8]};
        default: a = 12'hFCF + 12'(rng[15:8] % 8'd49);  // ID area up to 0xFFF
      endcase
      write_reg(a, 2'd2, xorshift32(rng));
      idle_cycle();
      wait_for_gready(1'b0, "reserved write");
      wait_for_gready(1'b1, "error response");
      repeat (2) idle_cycle();
    end
    close_test(3'd6);

    repeat (2) @(posedge HCLK);
    $display("Summary: %0d tests ok, %0d tests failed, %0d errors", n_pass, n_fail, n_err);
    if ((n_fail == 0) && (n_err == 0))
    begin
      $display("All tests passed!");
    end
    else
    begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
